//--- list.f
+incdir+design
design/lsu_pkg.sv
design/mem_decode.sv
design/mem_execute.sv
design/load_store_unit.sv
design/data_sram.sv
design/mem_result.sv
design/lsu_top.sv
verification/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the load/store testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f list.f -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- verification/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb;
  import lsu_pkg::*;

  typedef struct packed {
    logic [31:0]  instr;
    logic [4:0]   rd;
    logic [31:0]  value;
    fault_cause_t fault;
    logic [2:0]   latency;
  } table_entry_t;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [2:0] F3_BYTE    = 3'b000;
  localparam logic [2:0] F3_HALF    = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [2:0] F3_BYTE_U  = 3'b100;
  localparam logic [2:0] F3_HALF_U  = 3'b101;

  logic         clock;
  logic         reset;
  logic         instr_valid;
  instr_word_t  instr;
  logic         busy;
  logic         retire_valid;
  logic [4:0]   retire_rd;
  logic [31:0]  retire_value;
  fault_cause_t retire_fault;

  table_entry_t stimulus[$];
  logic [31:0]  model_regs [`LSU_REG_COUNT];
  logic [31:0]  model_mem [`LSU_MEM_WORDS];
  logic [31:0]  lfsr_state;
  int           cycle_count;
  int           cycle_limit;

  lsu_top UUT (
    .clock, .reset, .instr_valid, .instr, .busy,
    .retire_valid, .retire_rd, .retire_value, .retire_fault
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_word();
    logic [31:0] word;
    logic        bit_out;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      word = {word[30:0], bit_out};
    end
    return word;
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic is_misaligned(logic [1:0] size, logic [1:0] offset);
    return (size == 2'd1 && offset == 2'd3) || (size == 2'd2 && offset != 2'd0);
  endfunction

  task automatic push_entry(logic [31:0] word, logic [4:0] rd, logic [31:0] value,
                            fault_cause_t fault, logic [2:0] latency);
    table_entry_t entry;
    entry.instr   = word;
    entry.rd      = rd;
    entry.value   = value;
    entry.fault   = fault;
    entry.latency = latency;
    stimulus.push_back(entry);
  endtask

  task automatic write_reg(logic [4:0] rd, logic [31:0] value);
    if (rd != 5'd0) begin
      model_regs[rd] = value;
    end
  endtask

  task automatic addi_entry(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    logic [31:0] value;
    value = model_regs[rs1] + sext12(imm);
    push_entry({imm, rs1, 3'b000, rd, OPC_OP_IMM}, rd, value, FAULT_NONE, 3'd3);
    write_reg(rd, value);
  endtask

  task automatic lui_entry(logic [4:0] rd, logic [19:0] imm);
    push_entry({imm, rd, OPC_LUI}, rd, {imm, 12'h000}, FAULT_NONE, 3'd3);
    write_reg(rd, {imm, 12'h000});
  endtask

  task automatic load_entry(logic [2:0] funct3, logic [4:0] rd, logic [4:0] rs1,
                            logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] value;
    logic [31:0] encoded;
    logic [1:0]  offset;
    addr    = model_regs[rs1] + sext12(imm);
    offset  = addr[1:0];
    encoded = {imm, rs1, funct3, rd, OPC_LOAD};
    if (is_misaligned(funct3[1:0], offset)) begin
      push_entry(encoded, rd, 32'h0, FAULT_LOAD_MISALIGNED, 3'd4);
    end else begin
      word = model_mem[addr[9:2]];
      case (funct3[1:0])
        2'd0: begin
          value = 32'(word[8*offset +: 8]);
          if (!funct3[2] && value[7]) begin
            value[31:8] = '1;
          end
        end
        2'd1: begin
          value = 32'(word[8*offset +: 16]);
          if (!funct3[2] && value[15]) begin
            value[31:16] = '1;
          end
        end
        default: value = word;
      endcase
      push_entry(encoded, rd, value, FAULT_NONE, 3'd0);
      write_reg(rd, value);
    end
  endtask

  task automatic store_entry(logic [2:0] funct3, logic [4:0] rs2, logic [4:0] rs1,
                             logic [11:0] imm);
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] encoded;
    int          lane;
    addr    = model_regs[rs1] + sext12(imm);
    data    = model_regs[rs2];
    encoded = {imm[11:5], rs2, rs1, funct3, imm[4:0], OPC_STORE};
    if (is_misaligned(funct3[1:0], addr[1:0])) begin
      push_entry(encoded, 5'd0, 32'h0, FAULT_STORE_MISALIGNED, 3'd4);
    end else begin
      for (int i = 0; i < (1 << funct3[1:0]); i++) begin
        lane = addr[1:0] + i;
        model_mem[addr[9:2]][8*lane +: 8] = data[8*i +: 8];
      end
      push_entry(encoded, 5'd0, 32'h0, FAULT_NONE, 3'd0);
    end
  endtask

  task automatic set_random_reg(logic [4:0] rd);
    logic [31:0] r;
    r = random_word();
    lui_entry(rd, r[31:12]);
    addi_entry(rd, rd, r[11:0]);
  endtask

  task automatic build_table();
    addi_entry(5'd1, 5'd0, 12'h040);
    lui_entry(5'd5, 20'hABCDE);
    addi_entry(5'd0, 5'd5, 12'h005);
    // x0 must still read zero here
    addi_entry(5'd6, 5'd0, 12'h007);
    addi_entry(5'd7, 5'd0, 12'h800);
    set_random_reg(5'd2);
    store_entry(F3_WORD, 5'd2, 5'd1, 12'h000);
    load_entry(F3_WORD, 5'd3, 5'd1, 12'h000);
    for (int off = 0; off < 4; off++) begin
      set_random_reg(5'd2);
      store_entry(F3_BYTE, 5'd2, 5'd1, 12'(4 + off));
      load_entry(F3_WORD, 5'd3, 5'd1, 12'h004);
    end
    for (int off = 0; off < 3; off++) begin
      set_random_reg(5'd2);
      store_entry(F3_HALF, 5'd2, 5'd1, 12'(8 + off));
      load_entry(F3_WORD, 5'd3, 5'd1, 12'h008);
    end
    // Bytes 01 80 7f f0 mix both signs across the lanes
    lui_entry(5'd4, 20'hF07F8);
    addi_entry(5'd4, 5'd4, 12'h001);
    store_entry(F3_WORD, 5'd4, 5'd1, 12'h00C);
    for (int off = 0; off < 4; off++) begin
      load_entry(F3_BYTE, 5'd10, 5'd1, 12'(12 + off));
      load_entry(F3_BYTE_U, 5'd11, 5'd1, 12'(12 + off));
    end
    for (int off = 0; off < 3; off++) begin
      load_entry(F3_HALF, 5'd10, 5'd1, 12'(12 + off));
      load_entry(F3_HALF_U, 5'd11, 5'd1, 12'(12 + off));
    end
    load_entry(F3_HALF, 5'd3, 5'd1, 12'h00F);
    load_entry(F3_WORD, 5'd3, 5'd1, 12'h00E);
    store_entry(F3_WORD, 5'd4, 5'd1, 12'h001);
    load_entry(F3_WORD, 5'd8, 5'd1, 12'h000);
    addi_entry(5'd9, 5'd3, 12'h000);
    addi_entry(5'd12, 5'd0, 12'h0AB);
    push_entry({20'h12345, 5'd12, 7'b1111111}, 5'd12, 32'h0, FAULT_ILLEGAL, 3'd3);
    addi_entry(5'd13, 5'd12, 12'h000);
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("Run timed out after %0d cycles without finishing", cycle_count);
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
      end
    end
  end

  initial begin
    int cycles;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = 32'h8c7c_eb10;
    for (int i = 0; i < `LSU_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    build_table();
    cycle_limit = 64 * stimulus.size() + 16;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int n = 0; n < stimulus.size(); n++) begin
      @(posedge clock);
      #1;
      // Previous retire has released busy
      check_value("busy", 32'(busy), 32'h0);
      instr_valid = 1'b1;
      instr       = stimulus[n].instr;
      cycles      = 0;
      do begin
        @(posedge clock);
        #1;
        instr_valid = 1'b0;
        cycles++;
        check_value("busy", 32'(busy), 32'h1);
      end while (!retire_valid);
      if (stimulus[n].latency != 3'd0) begin
        check_value("retire latency", 32'(cycles), 32'(stimulus[n].latency));
      end
      check_value("retire_rd", 32'(retire_rd), 32'(stimulus[n].rd));
      check_value("retire_value", retire_value, stimulus[n].value);
      check_value("retire_fault", 32'(retire_fault), 32'(stimulus[n].fault));
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  instr_valid,
  input  lsu_pkg::instr_word_t  instr,
  output logic                  busy,
  output logic                  retire_valid,
  output logic [4:0]            retire_rd,
  output logic [31:0]           retire_value,
  output lsu_pkg::fault_cause_t retire_fault
);
  import lsu_pkg::*;

  logic          decoded_valid;
  decoded_op_t   decoded;
  logic          mem_valid;
  mem_request_t  mem_request;
  logic          alu_valid;
  alu_result_t   alu_result;
  logic          alu_fault;
  logic          mem_done;
  mem_response_t mem_response;
  writeback_t    writeback;

  logic        arvalid, arready, rvalid, rready;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic [31:0] araddr, rdata, awaddr, wdata;
  logic [2:0]  arsize, awsize;
  logic [1:0]  rresp, bresp;
  logic [3:0]  wstrb;

  mem_decode u_decode (
    .clock, .reset, .instr_valid, .instr, .decoded_valid, .decoded
  );

  mem_execute u_execute (
    .clock, .reset, .decoded_valid, .decoded, .writeback,
    .mem_valid, .mem_request, .alu_valid, .alu_result, .alu_fault
  );

  load_store_unit u_lsu (
    .clock, .reset, .mem_valid, .mem_request, .mem_done, .mem_response,
    .arvalid, .araddr, .arsize, .arready, .rvalid, .rdata, .rresp, .rready,
    .awvalid, .awaddr, .awsize, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready
  );

  data_sram u_sram (
    .clock, .reset,
    .arvalid, .araddr, .arsize, .arready, .rvalid, .rdata, .rresp, .rready,
    .awvalid, .awaddr, .awsize, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready
  );

  mem_result u_result (
    .clock, .reset, .alu_valid, .alu_result, .alu_fault, .mem_done, .mem_response,
    .writeback, .retire_valid, .retire_rd, .retire_value, .retire_fault
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (instr_valid) begin
      busy <= 1'b1;
    end else if (retire_valid) begin
      busy <= 1'b0;
    end
  end

  // One instruction in flight
  assert property (@(posedge clock) disable iff (reset) !(instr_valid && busy));

endmodule

//--- design/mem_result.sv
`timescale 1ns/1ps

module mem_result (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   alu_valid,
  input  lsu_pkg::alu_result_t   alu_result,
  input  logic                   alu_fault,
  input  logic                   mem_done,
  input  lsu_pkg::mem_response_t mem_response,
  output lsu_pkg::writeback_t    writeback,
  output logic                   retire_valid,
  output logic [4:0]             retire_rd,
  output logic [31:0]            retire_value,
  output lsu_pkg::fault_cause_t  retire_fault
);
  import lsu_pkg::*;

  logic         write_enable;
  logic         alu_writes;
  logic         mem_writes;
  fault_cause_t mem_cause;

  assign alu_writes = alu_valid && !alu_fault && alu_result.rd != 5'd0;
  assign mem_writes = mem_done && !mem_response.fault && !mem_response.is_store &&
                      mem_response.rd != 5'd0;
  assign mem_cause  = !mem_response.fault ? FAULT_NONE :
                      mem_response.is_store ? FAULT_STORE_MISALIGNED : FAULT_LOAD_MISALIGNED;

  assign writeback = '{enable: write_enable, rd: retire_rd, value: retire_value};

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
      write_enable <= 1'b0;
    end else begin
      retire_valid <= alu_valid || mem_done;
      write_enable <= alu_writes || mem_writes;
    end
  end

  always_ff @(posedge clock) begin
    if (alu_valid) begin
      retire_rd    <= alu_result.rd;
      retire_value <= alu_fault ? '0 : alu_result.value;
      retire_fault <= alu_fault ? FAULT_ILLEGAL : FAULT_NONE;
    end else if (mem_done) begin
      retire_rd    <= mem_response.rd;
      // Stores and faults report zero
      retire_value <= mem_response.is_store ? '0 : mem_response.value;
      retire_fault <= mem_cause;
    end
  end

  assert property (@(posedge clock) disable iff (reset) !(alu_valid && mem_done));

endmodule

//--- design/data_sram.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module data_sram (
  input  logic        clock,
  input  logic        reset,

  input  logic        arvalid,
  input  logic [31:0] araddr,
  input  logic [2:0]  arsize,
  output logic        arready,

  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        rready,

  input  logic        awvalid,
  input  logic [31:0] awaddr,
  input  logic [2:0]  awsize,
  output logic        awready,

  input  logic        wvalid,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        wready,

  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready
);
  localparam int INDEX_BITS = $clog2(`LSU_MEM_WORDS);
  localparam int WAIT_BITS  = $clog2(`LSU_MEM_DELAY + 1);

  logic [31:0]           mem [`LSU_MEM_WORDS];
  logic                  resp_pending;
  logic                  resp_write;
  logic [WAIT_BITS-1:0]  resp_wait;
  logic                  idle;
  logic                  read_accept;
  logic                  write_accept;
  logic [INDEX_BITS-1:0] read_index;
  logic [INDEX_BITS-1:0] write_index;

  assign idle         = !resp_pending;
  assign arready      = idle;
  assign awready      = idle;
  assign wready       = idle;
  assign read_accept  = arvalid && idle;
  assign write_accept = awvalid && wvalid && idle && !arvalid;
  assign read_index   = araddr[INDEX_BITS+1:2];
  assign write_index  = awaddr[INDEX_BITS+1:2];

  assign rvalid = resp_pending && !resp_write && resp_wait == '0;
  assign bvalid = resp_pending && resp_write && resp_wait == '0;
  assign rresp  = 2'b00;
  assign bresp  = 2'b00;

  always_ff @(posedge clock) begin
    if (reset) begin
      resp_pending <= 1'b0;
      resp_write   <= 1'b0;
      resp_wait    <= '0;
      // Contents start at zero
      for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (read_accept || write_accept) begin
        resp_pending <= 1'b1;
        resp_write   <= write_accept;
        resp_wait    <= WAIT_BITS'(`LSU_MEM_DELAY - 1);
      end else if (resp_pending && resp_wait != '0) begin
        resp_wait <= resp_wait - 1'b1;
      end else if ((rvalid && rready) || (bvalid && bready)) begin
        resp_pending <= 1'b0;
      end
      if (read_accept) begin
        rdata <= mem[read_index];
      end
      if (write_accept) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (wstrb[lane]) begin
            mem[write_index][8*lane +: 8] <= wdata[8*lane +: 8];
          end
        end
      end
    end
  end

  // Every accepted access fits inside one word
  assert property (@(posedge clock) disable iff (reset)
    read_accept |-> ({1'b0, araddr[1:0]} + (3'd1 << arsize[1:0])) <= 3'd4);
  assert property (@(posedge clock) disable iff (reset)
    write_accept |-> ({1'b0, awaddr[1:0]} + (3'd1 << awsize[1:0])) <= 3'd4);

endmodule

//--- design/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   mem_valid,
  input  lsu_pkg::mem_request_t  mem_request,
  output logic                   mem_done,
  output lsu_pkg::mem_response_t mem_response,

  output logic                   arvalid,
  output logic [31:0]            araddr,
  output logic [2:0]             arsize,
  input  logic                   arready,

  input  logic                   rvalid,
  input  logic [31:0]            rdata,
  input  logic [1:0]             rresp,
  output logic                   rready,

  output logic                   awvalid,
  output logic [31:0]            awaddr,
  output logic [2:0]             awsize,
  input  logic                   awready,

  output logic                   wvalid,
  output logic [31:0]            wdata,
  output logic [3:0]             wstrb,
  input  logic                   wready,

  input  logic                   bvalid,
  input  logic [1:0]             bresp,
  output logic                   bready
);
  import lsu_pkg::*;

  mem_request_t req;
  logic         misaligned;
  logic [1:0]   offset;
  logic [3:0]   base_strb;
  logic [31:0]  shifted;
  logic [31:0]  load_value;

  // Half access may cross a lane pair but not the word edge
  always_comb begin
    case (mem_request.size)
      SIZE_HALF: misaligned = mem_request.addr[1:0] == 2'd3;
      SIZE_WORD: misaligned = mem_request.addr[1:0] != 2'd0;
      default:   misaligned = 1'b0;
    endcase
  end

  assign offset = req.addr[1:0];
  assign araddr = req.addr;
  assign awaddr = req.addr;
  assign arsize = {1'b0, req.size};
  assign awsize = {1'b0, req.size};

  always_comb begin
    case (req.size)
      SIZE_BYTE: base_strb = 4'b0001;
      SIZE_HALF: base_strb = 4'b0011;
      default:   base_strb = 4'b1111;
    endcase
  end

  assign wstrb   = base_strb << offset;
  assign wdata   = req.store_data << {offset, 3'b000};
  assign shifted = rdata >> {offset, 3'b000};

  always_comb begin
    case (req.size)
      SIZE_BYTE: load_value = {{24{req.sext & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: load_value = {{16{req.sext & shifted[15]}}, shifted[15:0]};
      default:   load_value = shifted;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bready   <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (mem_valid) begin
        arvalid  <= !misaligned && !mem_request.is_store;
        awvalid  <= !misaligned && mem_request.is_store;
        wvalid   <= !misaligned && mem_request.is_store;
        mem_done <= misaligned;
      end
      if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (rvalid && rready) begin
        rready   <= 1'b0;
        mem_done <= 1'b1;
      end
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        bready <= 1'b1;
      end
      if (bvalid && bready) begin
        bready   <= 1'b0;
        mem_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      req          <= mem_request;
      mem_response <= '{rd: mem_request.rd, is_store: mem_request.is_store,
                        fault: misaligned, value: '0};
    end
    if (rvalid && rready) begin
      mem_response.value <= load_value;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    $rose(awvalid) |-> $rose(wvalid));

  // Faulting request stays off the bus
  assert property (@(posedge clock) disable iff (reset)
    mem_valid && misaligned |=> !(arvalid || awvalid || wvalid));

  // On-chip memory never answers with an error
  assert property (@(posedge clock) disable iff (reset)
    !((rvalid && rready && rresp != 2'b00) || (bvalid && bready && bresp != 2'b00)));

endmodule

//--- design/mem_execute.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module mem_execute (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  decoded_valid,
  input  lsu_pkg::decoded_op_t  decoded,
  input  lsu_pkg::writeback_t   writeback,
  output logic                  mem_valid,
  output lsu_pkg::mem_request_t mem_request,
  output logic                  alu_valid,
  output lsu_pkg::alu_result_t  alu_result,
  output logic                  alu_fault
);
  import lsu_pkg::*;

  logic [31:0] regs [`LSU_REG_COUNT];
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  logic [31:0] sum;
  logic [31:0] alu_value;
  logic        is_mem;

  assign rs1_value = regs[decoded.rs1];
  assign rs2_value = regs[decoded.rs2];
  assign sum       = rs1_value + decoded.imm;
  assign is_mem    = (decoded.kind == OP_LOAD) || (decoded.kind == OP_STORE);

  always_comb begin
    case (decoded.kind)
      OP_ADDI: alu_value = sum;
      OP_LUI:  alu_value = decoded.imm << 12;
      default: alu_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `LSU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      mem_valid <= 1'b0;
      alu_valid <= 1'b0;
    end else begin
      // x0 is never written
      if (writeback.enable && writeback.rd != 5'd0) begin
        regs[writeback.rd] <= writeback.value;
      end
      mem_valid <= decoded_valid && is_mem;
      alu_valid <= decoded_valid && !is_mem;
    end
  end

  always_ff @(posedge clock) begin
    if (decoded_valid) begin
      mem_request <= '{is_store: decoded.kind == OP_STORE, size: decoded.size,
                       sext: decoded.sext, rd: decoded.rd, addr: sum,
                       store_data: rs2_value};
      alu_result  <= '{rd: decoded.rd, value: alu_value};
      alu_fault   <= decoded.kind == OP_ILLEGAL;
    end
  end

  // Shortest memory round trip back to a new decode is four cycles
  assert property (@(posedge clock) disable iff (reset)
    mem_valid |=> !decoded_valid [*3]);

endmodule

//--- design/mem_decode.sv
`timescale 1ns/1ps

module mem_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 instr_valid,
  input  lsu_pkg::instr_word_t instr,
  output logic                 decoded_valid,
  output lsu_pkg::decoded_op_t decoded
);
  import lsu_pkg::*;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  decoded_op_t next_op;
  logic [2:0]  funct3;

  assign funct3 = instr.i_view.funct3;

  always_comb begin
    next_op      = '0;
    next_op.kind = OP_ILLEGAL;
    next_op.size = SIZE_WORD;
    next_op.rd   = instr.i_view.rd;
    next_op.rs1  = instr.i_view.rs1;
    next_op.rs2  = instr.s_view.rs2;
    case (instr.i_view.opcode)
      OPC_LOAD: begin
        // LB LH LW LBU LHU
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          next_op.kind = OP_LOAD;
          next_op.size = access_size_t'(funct3[1:0]);
          next_op.sext = !funct3[2];
          next_op.imm  = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
        end
      end
      OPC_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          next_op.kind = OP_STORE;
          next_op.size = access_size_t'(funct3[1:0]);
          next_op.rd   = '0;
          next_op.imm  = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi,
                          instr.s_view.imm_lo};
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          next_op.kind = OP_ADDI;
          next_op.imm  = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
        end
      end
      OPC_LUI: begin
        next_op.kind = OP_LUI;
        next_op.rs1  = '0;
        next_op.imm  = {{12{instr.u_view.imm[19]}}, instr.u_view.imm};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      decoded_valid <= 1'b0;
    end else begin
      decoded_valid <= instr_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid) begin
      decoded <= next_op;
    end
  end

endmodule

//--- design/lsu_pkg.sv
package lsu_pkg;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_view_t;

  // Same instruction word seen through the I, S and U formats
  typedef union packed {
    i_view_t i_view;
    s_view_t s_view;
    u_view_t u_view;
  } instr_word_t;

  typedef enum logic [2:0] {
    OP_LOAD,
    OP_STORE,
    OP_ADDI,
    OP_LUI,
    OP_ILLEGAL
  } op_kind_t;

  // Encoded as the AXI size field
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  typedef enum logic [1:0] {
    FAULT_NONE,
    FAULT_LOAD_MISALIGNED,
    FAULT_STORE_MISALIGNED,
    FAULT_ILLEGAL
  } fault_cause_t;

  typedef struct packed {
    op_kind_t     kind;
    access_size_t size;
    logic         sext;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [31:0]  imm;
  } decoded_op_t;

  typedef struct packed {
    logic         is_store;
    access_size_t size;
    logic         sext;
    logic [4:0]   rd;
    logic [31:0]  addr;
    logic [31:0]  store_data;
  } mem_request_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
  } alu_result_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic        is_store;
    logic        fault;
    logic [31:0] value;
  } mem_response_t;

  typedef struct packed {
    logic        enable;
    logic [4:0]  rd;
    logic [31:0] value;
  } writeback_t;

endpackage

//--- design/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Architectural integer registers
`define LSU_REG_COUNT 32

// Data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// Cycles from address acceptance to response valid
`define LSU_MEM_DELAY 1

`endif
